/* nibble_loop.f */
+incdir+verif
src/nibble_alu_pkg.sv
src/nibble_seq_pkg.sv
src/nibble_sequencer.sv
src/nibble_alu.sv
src/nibble_result_assembler.sv
src/nibble_loop_unit.sv
verif/tb_nibble_loop_unit.sv

/* run_sim.sh */
#!/bin/sh
# builds the nibble loop unit testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

TOP=tb_nibble_loop_unit
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -f nibble_loop.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

exit 0

/* verif/tb_nibble_loop_ref.svh */
// reference model, operand LFSR and value check for the nibble loop unit testbench
`ifndef TB_NIBBLE_LOOP_REF_SVH
`define TB_NIBBLE_LOOP_REF_SVH

// Galois form of x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
endfunction

task automatic check_value(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        error_count++;
        $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h",
                 $time, what, got, expected);
    end else begin
        pass_count++;
    end
endtask

// expected result, final carry and number of processed nibbles
function automatic void ref_model(
    input  alu_op_t           f_op,
    input  logic [WORD_W-1:0] a,
    input  logic [WORD_W-1:0] b,
    input  logic [WORD_W-1:0] pre,
    input  logic [IDX_W-1:0]  m,
    output logic [WORD_W-1:0] res,
    output logic              cy,
    output int                n
);
    logic [63:0]       mask;
    logic [63:0]       field;
    logic [63:0]       top;
    logic [NIBBLE_W:0] part;
    int                width;
    int                sh;
    logic              more;
    if ((f_op == ADD) && (m == '0)) begin
        // increment: ripple upward while the carry survives, at most a full word
        res  = pre;
        cy   = 1'b0;
        n    = 0;
        more = 1'b1;
        while (more) begin
            sh   = NIBBLE_W * n;
            part = 5'(4'(a >> sh)) + 5'(4'(b >> sh)) + 5'(cy);
            res  = (res & ~(32'hF << sh)) | (32'(part[3:0]) << sh);
            cy   = part[NIBBLE_W];
            n++;
            more = cy && (n < NIBBLES);
        end
    end else begin
        width = NIBBLE_W * (int'(m) + 1);
        mask  = (64'd1 << width) - 64'd1;
        n     = int'(m) + 1;
        case (f_op)
            ADD:     field = (64'(a) & mask) + (64'(b) & mask);
            SUB:     field = (64'(a) & mask) + (64'(~b) & mask) + 64'd1;
            AND:     field = 64'(a & b);
            XOR:     field = 64'(a ^ b);
            RSHFT:   field = (64'(a) & mask) >> 1;
            default: field = 64'd0;
        endcase
        // carry sits just above the field, RSHFT returns the bit shifted out
        top = field >> width;
        cy  = (f_op == RSHFT) ? a[0] : (((f_op == ADD) || (f_op == SUB)) && top[0]);
        res = (pre & ~mask[WORD_W-1:0]) | (field[WORD_W-1:0] & mask[WORD_W-1:0]);
    end
endfunction

`endif

/* verif/tb_nibble_loop_unit.sv */
// testbench for the nibble loop unit with directed and random handshake transactions
`timescale 1ns/1ns

module tb_nibble_loop_unit
    import nibble_alu_pkg::*, nibble_seq_pkg::*;
();

    localparam int RESET_CYCLES   = 16;
    localparam int TXN_COUNT      = 40;
    // worst transaction is about 13 cycles, margin covers the held requests
    localparam int TIMEOUT_CYCLES = TXN_COUNT * 14 + RESET_CYCLES + 100;

    localparam logic [WORD_W-1:0] INC_WORDS [5] = '{
        32'h1234567F, 32'hABCDE0FF, 32'hFFFFFFFF, 32'h00000123, 32'h0FFFFFFF
    };

    logic              clk;
    logic              rst_n;
    logic              req;
    alu_op_t           op;
    logic [WORD_W-1:0] word_a;
    logic [WORD_W-1:0] word_b;
    logic [WORD_W-1:0] preset;
    logic [IDX_W-1:0]  nibbles_m1;
    logic              ack;
    logic [WORD_W-1:0] result;
    logic              carry_out;

    // expectations for the open transaction
    logic [WORD_W-1:0] exp_result;
    logic              exp_carry;
    int                exp_n;
    int                req_edge;

    int          cycle_cnt   = 0;
    int          error_count = 0;
    int          pass_count  = 0;
    logic [31:0] lfsr_state  = 32'h561a;
    logic        ack_prev    = 1'b0;

    `include "tb_nibble_loop_ref.svh"

    nibble_loop_unit nibble_loop_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .word_a     (word_a),
        .word_b     (word_b),
        .preset     (preset),
        .nibbles_m1 (nibbles_m1),
        .ack        (ack),
        .result     (result),
        .carry_out  (carry_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: no finish after %0d cycles, ack never came back", cycle_cnt);
        $display("Regression failed");
        $finish;
    end

    // checks every rising ack against the reference model
    initial begin : compare
        forever begin
            @(negedge clk);
            if (ack && !ack_prev) begin
                check_value("result", result, exp_result);
                check_value("carry_out", 32'(carry_out), 32'(exp_carry));
                check_value("ack latency", cycle_cnt - req_edge, exp_n + 2);
            end
            ack_prev = ack;
        end
    end

    // one bit per LFSR step
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < count; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    task automatic run_txn(input alu_op_t t_op, input logic [WORD_W-1:0] t_a,
                           input logic [WORD_W-1:0] t_b, input logic [WORD_W-1:0] t_pre,
                           input logic [IDX_W-1:0] t_m, input int hold);
        ref_model(t_op, t_a, t_b, t_pre, t_m, exp_result, exp_carry, exp_n);
        @(negedge clk);
        op         = t_op;
        word_a     = t_a;
        word_b     = t_b;
        preset     = t_pre;
        nibbles_m1 = t_m;
        req        = 1'b1;
        req_edge   = cycle_cnt + 1;
        while (!ack) @(negedge clk);
        // requester slow to let go, unit must sit in DONE
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("held ack", 32'(ack), 32'd1);
            check_value("held result", result, exp_result);
        end
        req = 1'b0;
        @(negedge clk);
        check_value("ack after req drop", 32'(ack), 32'd0);
    endtask

    task automatic report_test(input string name, input int err_start, input int pass_start);
        $display("test %s done: %0d checks passed, %0d errors",
                 name, pass_count - pass_start, error_count - err_start);
    endtask

    initial begin : stimulus
        int      err_start;
        int      pass_start;
        alu_op_t t_op;
        rst_n      = 1'b0;
        req        = 1'b0;
        op         = ADD;
        word_a     = '0;
        word_b     = '0;
        preset     = '0;
        nibbles_m1 = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err_start  = error_count;
        pass_start = pass_count;
        @(negedge clk);
        check_value("reset ack", 32'(ack), 32'd0);
        check_value("reset result", result, 32'd0);
        check_value("reset carry_out", 32'(carry_out), 32'd0);
        report_test("reset", err_start, pass_start);

        err_start  = error_count;
        pass_start = pass_count;
        run_txn(ADD, 32'h0EFFFFFF, 32'h1, take_bits(32), IDX_W'(7), 0);
        run_txn(ADD, 32'hFFFFFFFF, 32'h1, take_bits(32), IDX_W'(7), 0);
        run_txn(SUB, 32'h5, 32'h9, take_bits(32), IDX_W'(7), 0);
        for (int i = 0; i < 8; i++) begin
            t_op = take_bits(1) ? SUB : ADD;
            run_txn(t_op, take_bits(32), take_bits(32), take_bits(32), IDX_W'(7), 0);
        end
        report_test("full width", err_start, pass_start);

        err_start  = error_count;
        pass_start = pass_count;
        for (int i = 0; i < 12; i++) begin
            case (take_bits(2) % 3)
                0:       t_op = ADD;
                1:       t_op = AND;
                default: t_op = XOR;
            endcase
            run_txn(t_op, take_bits(32), take_bits(32), take_bits(32),
                    IDX_W'(1 + take_bits(3) % 6), 0);
        end
        report_test("partial width", err_start, pass_start);

        err_start  = error_count;
        pass_start = pass_count;
        for (int i = 0; i < 8; i++) begin
            run_txn(RSHFT, take_bits(32), 32'h0, take_bits(32), IDX_W'(take_bits(3)), 0);
        end
        report_test("right shift", err_start, pass_start);

        err_start  = error_count;
        pass_start = pass_count;
        for (int i = 0; i < 5; i++) begin
            run_txn(ADD, INC_WORDS[i], 32'h1, take_bits(32), IDX_W'(0), 0);
        end
        report_test("increment", err_start, pass_start);

        err_start  = error_count;
        pass_start = pass_count;
        for (int i = 0; i < 4; i++) begin
            t_op = alu_op_t'(3'(take_bits(3) % 5));
            run_txn(t_op, take_bits(32), take_bits(32), take_bits(32),
                    IDX_W'(take_bits(3)), 1 + int'(take_bits(3)));
        end
        report_test("handshake", err_start, pass_start);

        $display("checks passed: %0d, errors: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src/nibble_loop_unit.sv */
// nibble loop unit, the top of the nibble-serial 32-bit ALU with a req/ack handshake
`timescale 1ns/1ns

module nibble_loop_unit
    import nibble_alu_pkg::*, nibble_seq_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  alu_op_t           op,
    input  logic [WORD_W-1:0] word_a,
    input  logic [WORD_W-1:0] word_b,
    input  logic [WORD_W-1:0] preset,
    input  logic [IDX_W-1:0]  nibbles_m1,
    output logic              ack,
    output logic [WORD_W-1:0] result,
    output logic              carry_out
);

    logic                load;
    logic                step;
    logic [IDX_W-1:0]    idx;
    logic [NIBBLE_W-1:0] nib_res;
    logic                nib_carry;

    nibble_sequencer nibble_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .nibbles_m1 (nibbles_m1),
        .nib_carry  (nib_carry),
        .ack        (ack),
        .load       (load),
        .step       (step),
        .idx        (idx)
    );

    nibble_alu nibble_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .word_a    (word_a),
        .word_b    (word_b),
        .idx       (idx),
        .load      (load),
        .step      (step),
        .nib_res   (nib_res),
        .nib_carry (nib_carry),
        .carry_out (carry_out)
    );

    nibble_result_assembler nibble_result_assembler_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .preset  (preset),
        .idx     (idx),
        .load    (load),
        .step    (step),
        .nib_res (nib_res),
        .result  (result)
    );

endmodule

/* src/nibble_result_assembler.sv */
// result assembler that loads the preset word and writes ALU nibbles into it by index
`timescale 1ns/1ns

module nibble_result_assembler
    import nibble_alu_pkg::*, nibble_seq_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [WORD_W-1:0]   preset,
    input  logic [IDX_W-1:0]    idx,
    input  logic                load,
    input  logic                step,
    input  logic [NIBBLE_W-1:0] nib_res,
    output logic [WORD_W-1:0]   result
);

    // result held as nibbles so a single slice can be replaced
    logic [NIBBLES-1:0][NIBBLE_W-1:0] word_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (load) begin
            // nibbles outside the processed range keep these values
            word_q <= preset;
        end else if (step) begin
            word_q[idx] <= nib_res;
        end
    end

    // held stable through DONE until the next load
    assign result = word_q;

    // after a load the word only moves on a step
    no_write_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        (load ##1 !step) |=> $stable(result));

endmodule

/* src/nibble_alu.sv */
// nibble ALU that computes one 4-bit slice per cycle and keeps the carry between nibbles
`timescale 1ns/1ns

module nibble_alu
    import nibble_alu_pkg::*, nibble_seq_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  alu_op_t             op,
    input  logic [WORD_W-1:0]   word_a,
    input  logic [WORD_W-1:0]   word_b,
    input  logic [IDX_W-1:0]    idx,
    input  logic                load,
    input  logic                step,
    output logic [NIBBLE_W-1:0] nib_res,
    output logic                nib_carry,
    output logic                carry_out
);

    logic [NIBBLES-1:0][NIBBLE_W-1:0] a_nibs;
    logic [NIBBLES-1:0][NIBBLE_W-1:0] b_nibs;
    logic [NIBBLE_W-1:0]              a_nib;
    logic [NIBBLE_W-1:0]              b_nib;
    logic [NIBBLE_W-1:0]              b_eff;
    logic [NIBBLE_W:0]                sum;
    logic                             carry_q;

    // view both words as nibble arrays and pick the current slice
    assign a_nibs = word_a;
    assign b_nibs = word_b;
    assign a_nib  = a_nibs[idx];
    assign b_nib  = b_nibs[idx];

    // SUB is A + ~B with the carry acting as a no-borrow flag
    assign b_eff = (op == SUB) ? ~b_nib : b_nib;
    assign sum   = {1'b0, a_nib} + {1'b0, b_eff} + {{NIBBLE_W{1'b0}}, carry_q};

    always_comb begin
        nib_res   = '0;
        nib_carry = 1'b0;
        case (op)
            ADD, SUB: begin
                nib_res   = sum[NIBBLE_W-1:0];
                nib_carry = sum[NIBBLE_W];
            end
            AND: begin
                nib_res = a_nib & b_nib;
            end
            XOR: begin
                nib_res = a_nib ^ b_nib;
            end
            RSHFT: begin
                // bit dropped off the upper nibble enters at the top of this one
                nib_res   = {carry_q, a_nib[NIBBLE_W-1:1]};
                nib_carry = a_nib[0];
            end
            default: begin
                nib_res = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (load) begin
            carry_q <= (op == SUB);
        end else if (step) begin
            carry_q <= nib_carry;
        end
    end

    assign carry_out = carry_q;

    // sequencer keeps the load strobe and the run phase apart
    load_step_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(load && step));

endmodule

/* src/nibble_sequencer.sv */
// nibble sequencer that runs the req/ack handshake, the loop FSM and the nibble index
`timescale 1ns/1ns

module nibble_sequencer
    import nibble_alu_pkg::*, nibble_seq_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  alu_op_t          op,
    input  logic [IDX_W-1:0] nibbles_m1,
    // carry out of the nibble being processed this cycle
    input  logic             nib_carry,
    output logic             ack,
    output logic             load,
    output logic             step,
    output logic [IDX_W-1:0] idx
);

    seq_state_t       state;
    seq_state_t       state_next;
    logic [IDX_W-1:0] idx_q;
    logic [IDX_W-1:0] start_idx;
    logic             ack_q;
    logic             reverse;
    logic             inc_mode;
    logic             last_nibble;

    // RSHFT is the only op that walks from the top down
    assign reverse = (op == RSHFT);

    // single-nibble ADD is the program-counter increment case
    assign inc_mode = (op == ADD) && (nibbles_m1 == IDX_FIRST);

    assign start_idx = reverse ? nibbles_m1 : IDX_FIRST;

    // decides whether the nibble in flight is the final one
    always_comb begin
        if (inc_mode) begin
            // keep rippling while the carry survives and never past the top nibble
            last_nibble = !nib_carry || (idx_q == IDX_LAST);
        end else if (reverse) begin
            last_nibble = (idx_q == IDX_FIRST);
        end else begin
            last_nibble = (idx_q == nibbles_m1);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_next = LOAD;
                end
            end
            LOAD: begin
                state_next = RUN;
            end
            RUN: begin
                if (last_nibble) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                // leave only once the requester has seen ack and let go of req
                if (ack_q && !req) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ack_q <= 1'b0;
        end else begin
            state <= state_next;
            // ack comes one edge after DONE is entered and falls as DONE is left
            ack_q <= (state == DONE) && (state_next == DONE);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= IDX_FIRST;
        end else if (state == LOAD) begin
            idx_q <= start_idx;
        end else if ((state == RUN) && !last_nibble) begin
            idx_q <= reverse ? idx_q - IDX_W'(1) : idx_q + IDX_W'(1);
        end
    end

    assign ack  = ack_q;
    assign load = (state == LOAD);
    assign step = (state == RUN);
    assign idx  = idx_q;

    // ack must never be seen outside DONE
    ack_in_done: assert property (@(posedge clk) disable iff (!rst_n)
        ack_q |-> (state == DONE));

    // a run never starts straight out of IDLE without its load cycle
    no_step_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) |=> !step);

    // requester keeps op steady while the transaction is open
    op_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req && !ack_q) ##1 (req && !ack_q) |-> $stable(op));

endmodule

/* src/nibble_seq_pkg.sv */
// nibble sequencer package with the loop FSM states and nibble index constants
package nibble_seq_pkg;

    // width of the nibble index and of nibbles_m1
    localparam int IDX_W = 3;

    // lowest nibble, start of upward runs and end of RSHFT runs
    localparam logic [IDX_W-1:0] IDX_FIRST = '0;

    // highest nibble, caps the increment-mode run
    localparam logic [IDX_W-1:0] IDX_LAST = '1;

    // loop FSM states
    // LOAD lasts one cycle, RUN one cycle per nibble
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        RUN  = 2'd2,
        DONE = 2'd3
    } seq_state_t;

endpackage

/* src/nibble_alu_pkg.sv */
// nibble ALU package with the opcode set and datapath widths of the serial ALU
package nibble_alu_pkg;

    // width of one ALU slice
    localparam int NIBBLE_W = 4;

    // width of the operand and result words
    localparam int WORD_W = 32;

    // nibbles per word, also the longest possible run
    localparam int NIBBLES = WORD_W / NIBBLE_W;

    // opcodes understood by the nibble ALU
    // arithmetic and logic ops walk upward from nibble 0
    // RSHFT walks downward from the top processed nibble
    typedef enum logic [2:0] {
        ADD   = 3'd0,
        SUB   = 3'd1,
        AND   = 3'd2,
        XOR   = 3'd3,
        RSHFT = 3'd4
    } alu_op_t;

endpackage
